// File: build.f
+incdir+logic
logic/mipsPkg.sv
logic/controlDecoder.sv
logic/issueStage.sv
logic/stageSlot.sv
logic/hazardUnit.sv
logic/hazardPipeTop.sv
dv/clockGen.sv
dv/hazardPipeTb.sv

// File: dv/clockGen.sv
`default_nettype none

module clockGen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 50;  // 100 ns clock
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: dv/hazardPipeTb.sv
`include "mipsParams.svh"
`default_nettype none

module hazardPipeTb;
    timeunit 1ns;
    timeprecision 1ps;
    import mipsPkg::*;

    localparam int STALL_LIMIT  = 8;
    localparam int RESET_LIMIT  = 10;
    localparam int DRAIN_LIMIT  = 12;
    localparam int RETIRE_DELAY = 3;  // execute, memory, writeback

    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] FN_ADD     = 6'b100000;
    localparam logic [5:0] FN_SUB     = 6'b100010;
    localparam logic [5:0] FN_JR      = 6'b001000;

    typedef struct packed {
        instrWord_t instr;
        logic [3:0] stallCycles;  // cycles held in decode
        fwdSel_t    fwdRs;        // selectors once released
        fwdSel_t    fwdRt;
    } tableRow_t;

    logic       clk;
    logic       reset;
    instrWord_t fetchInstr;
    logic       stall;
    fwdSel_t    fwdRs;
    fwdSel_t    fwdRt;
    instrWord_t retireInstr;

    tableRow_t  rows[$];
    instrWord_t retireWords[$];
    int         retireDue[$];  // sample cycle each word must show up
    int         cycle;
    int         errors;

    clockGen clockGen_inst (
        .clk,
        .reset
    );

    hazardPipeTop hazardPipeTop_inst (
        .clk,
        .reset,
        .fetchInstr,
        .stall,
        .fwdRs,
        .fwdRt,
        .retireInstr
    );

    function automatic instrWord_t encodeR(
        input logic [5:0] funct,
        input regIndex_t  rs,
        input regIndex_t  rt,
        input regIndex_t  rd
    );
        return {OP_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic instrWord_t encodeI(
        input logic [5:0]  op,
        input regIndex_t   rs,
        input regIndex_t   rt,
        input logic [15:0] imm
    );
        return {op, rs, rt, imm};
    endfunction

    task automatic stopWithFailure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic checkValue(
        input string       what,
        input logic [31:0] got,
        input logic [31:0] expected
    );
        if (got !== expected) begin
            errors++;
            $display("[ERROR] %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
            stopWithFailure();
        end
    endtask

    task automatic addRow(input instrWord_t instr, input int stalls,
                          input fwdSel_t rs, input fwdSel_t rt);
        tableRow_t row;
        row.instr       = instr;
        row.stallCycles = stalls[3:0];
        row.fwdRs       = rs;
        row.fwdRt       = rt;
        rows.push_back(row);
    endtask

    task automatic fillTable();
        addRow(encodeI(OP_ORI, 5'd0, 5'd1, 16'h0011), 0, fwdNone, fwdNone);
        addRow(encodeI(OP_ORI, 5'd0, 5'd2, 16'h0022), 0, fwdNone, fwdNone);
        addRow(encodeI(OP_LUI, 5'd0, 5'd3, 16'h1234), 0, fwdNone, fwdNone);
        addRow(encodeR(FN_ADD, 5'd5, 5'd6, 5'd4), 0, fwdNone, fwdNone);
        addRow(encodeR(FN_ADD, 5'd5, 5'd6, 5'd7), 0, fwdNone, fwdNone);
        addRow('0, 0, fwdNone, fwdNone);
        addRow(encodeR(FN_SUB, 5'd7, 5'd5, 5'd8), 0, fwdMemory, fwdNone);  // add $7 in memory
        addRow(encodeR(FN_ADD, 5'd5, 5'd6, 5'd9), 0, fwdNone, fwdNone);
        addRow('0, 0, fwdNone, fwdNone);
        addRow('0, 0, fwdNone, fwdNone);
        addRow(encodeR(FN_SUB, 5'd5, 5'd9, 5'd11), 0, fwdNone, fwdWriteback);
        addRow(encodeR(FN_ADD, 5'd11, 5'd0, 5'd12), 0, fwdNone, fwdNone);  // $11 not ready yet
        addRow(encodeI(OP_LW, 5'd5, 5'd13, 16'h0004), 0, fwdNone, fwdNone);
        addRow(encodeR(FN_ADD, 5'd5, 5'd13, 5'd14), 1, fwdNone, fwdNone);  // load-use bubble
        addRow(encodeI(OP_LW, 5'd0, 5'd15, 16'h0000), 0, fwdNone, fwdNone);
        addRow(encodeI(OP_SW, 5'd0, 5'd15, 16'h0008), 0, fwdNone, fwdNone);  // store data late
        addRow(encodeI(OP_LW, 5'd0, 5'd16, 16'h0000), 0, fwdNone, fwdNone);
        addRow(encodeI(OP_BEQ, 5'd16, 5'd16, 16'h0003), 0, fwdNone, fwdNone);
        addRow(encodeR(FN_JR, 5'd16, 5'd0, 5'd0), 0, fwdNone, fwdNone);
        addRow(encodeI(OP_LW, 5'd5, 5'd0, 16'h0000), 0, fwdNone, fwdNone);  // load into $0
        addRow(encodeR(FN_ADD, 5'd0, 5'd0, 5'd18), 0, fwdNone, fwdNone);
        addRow({OP_JAL, 26'h0000040}, 0, fwdNone, fwdNone);
        addRow(encodeR(FN_ADD, 5'd31, 5'd0, 5'd19), 0, fwdExecute, fwdNone);  // link ready
        addRow(encodeI(OP_ORI, 5'd0, 5'd20, 16'h0001), 0, fwdNone, fwdNone);
        addRow(encodeI(OP_ORI, 5'd0, 5'd20, 16'h0002), 0, fwdNone, fwdNone);
        addRow(encodeR(FN_ADD, 5'd20, 5'd20, 5'd21), 0, fwdNone, fwdNone);  // youngest wins
    endtask

    // retire order is checked on every output sample
    task automatic stepSample();
        @(negedge clk);
        cycle++;
        if (retireDue.size() > 0 && retireDue[0] == cycle) begin
            checkValue("retireInstr", retireInstr, retireWords[0]);
            void'(retireDue.pop_front());
            void'(retireWords.pop_front());
        end else begin
            checkValue("retireInstr between results", retireInstr, '0);
        end
    endtask

    initial begin
        int        waitCount;
        int        stallCycles;
        tableRow_t row;
        fetchInstr = encodeI(OP_LW, 5'd1, 5'd1, 16'h0000);  // non-nop word as reset starts
        cycle      = 0;
        errors     = 0;
        waitCount  = 0;
        fillTable();

        @(posedge clk);
        fetchInstr <= '0;
        @(negedge clk);
        while (reset !== 1'b0) begin
            if (waitCount == RESET_LIMIT) begin
                $display("timeout: reset was not released");
                stopWithFailure();
            end
            waitCount++;
            @(negedge clk);
        end
        checkValue("stall after reset", stall, 1'b0);
        checkValue("fwdRs after reset", fwdRs, fwdNone);
        checkValue("fwdRt after reset", fwdRt, fwdNone);
        checkValue("retireInstr after reset", retireInstr, '0);

        @(posedge clk);
        fetchInstr <= rows[0].instr;
        @(posedge clk);
        fetchInstr <= rows[1].instr;  // row 0 captured on this edge

        for (int i = 0; i < rows.size(); i++) begin
            row         = rows[i];
            stallCycles = 0;
            stepSample();
            while (stall) begin
                if (stallCycles == STALL_LIMIT) begin
                    $display("timeout: decode stayed stalled on row %0d", i);
                    stopWithFailure();
                end
                stallCycles++;
                stepSample();
            end
            checkValue($sformatf("row %0d stall cycles", i), stallCycles, row.stallCycles);
            checkValue($sformatf("row %0d fwdRs", i), fwdRs, row.fwdRs);
            checkValue($sformatf("row %0d fwdRt", i), fwdRt, row.fwdRt);
            if (row.instr != '0) begin
                retireWords.push_back(row.instr);
                retireDue.push_back(cycle + RETIRE_DELAY);
            end
            @(posedge clk);
            fetchInstr <= (i + 2 < rows.size()) ? rows[i + 2].instr : '0;
        end

        waitCount = 0;
        while (retireDue.size() > 0) begin
            if (waitCount == DRAIN_LIMIT) begin
                $display("timeout: %0d instructions never retired", retireDue.size());
                stopWithFailure();
            end
            waitCount++;
            stepSample();
        end

        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/controlDecoder.sv
`include "mipsParams.svh"
`default_nettype none

module controlDecoder #(
    parameter int PIPELINE = `STAGE_DEFAULT
) (
    input  wire mipsPkg::instrWord_t instr,
    output mipsPkg::ctrlBundle_t     ctrl
);
    import mipsPkg::*;

    // result distance from this stage
    localparam timing_t ALU_NEW = (PIPELINE < `STAGE_MEMORY) ?
        timing_t'(`STAGE_MEMORY - PIPELINE) : `T_NEW_IGNORE;
    localparam timing_t LOAD_NEW = (PIPELINE < `STAGE_WRITEBACK) ?
        timing_t'(`STAGE_WRITEBACK - PIPELINE) : `T_NEW_IGNORE;
    localparam timing_t LINK_NEW = (PIPELINE < `STAGE_EXECUTE) ?
        timing_t'(`STAGE_EXECUTE - PIPELINE) : `T_NEW_IGNORE;

    opcode_t   opcode;
    funct_t    funct;
    regIndex_t rt;
    logic      isNop;

    assign opcode = instr[`OPCODE_MSB:`OPCODE_LSB];
    assign funct  = instr[`FUNCT_MSB:`FUNCT_LSB];
    assign rt     = instr[`RT_MSB:`RT_LSB];
    assign isNop  = (opcode == '0) && (funct == '0) && (rt == '0);

    always_comb begin
        // idle bundle, each opcode overrides what it needs
        ctrl.branch   = `BRANCH_DISABLE;
        ctrl.jump     = `JUMP_DISABLE;
        ctrl.cmpSrc   = `CMPSRC_IGNORE;
        ctrl.cmpOp    = `CMPOP_IGNORE;
        ctrl.extOp    = `EXTOP_IGNORE;
        ctrl.aluSrc   = `ALUSRC_IGNORE;
        ctrl.aluOp    = `ALUOP_IGNORE;
        ctrl.dmOp     = `DMOP_IGNORE;
        ctrl.regSrc   = `REGSRC_IGNORE;
        ctrl.regDst   = `REGDST_IGNORE;
        ctrl.regWrite = `REGWRITE_DISABLE;
        ctrl.tUseRs   = `T_USE_IGNORE;
        ctrl.tUseRt   = `T_USE_IGNORE;
        ctrl.tNew     = `T_NEW_IGNORE;
        if (!isNop) begin
            case (opcode)
                6'b000000: begin
                    case (funct)
                        6'b100000: begin  // add
                            ctrl.aluSrc   = {`ALUSRC2_RT, `ALUSRC1_RS};
                            ctrl.aluOp    = `ALUOP_ADD;
                            ctrl.regSrc   = `REGSRC_ALU;
                            ctrl.regDst   = `REGDST_RD;
                            ctrl.regWrite = `REGWRITE_NOCOND;
                            ctrl.tUseRs   = 2'd1;
                            ctrl.tUseRt   = 2'd1;
                            ctrl.tNew     = ALU_NEW;
                        end
                        6'b100010: begin  // sub
                            ctrl.aluSrc   = {`ALUSRC2_RT, `ALUSRC1_RS};
                            ctrl.aluOp    = `ALUOP_SUB;
                            ctrl.regSrc   = `REGSRC_ALU;
                            ctrl.regDst   = `REGDST_RD;
                            ctrl.regWrite = `REGWRITE_NOCOND;
                            ctrl.tUseRs   = 2'd1;
                            ctrl.tUseRt   = 2'd1;
                            ctrl.tNew     = ALU_NEW;
                        end
                        6'b001000: ctrl.jump = `JUMP_REG;  // jr
                        default: ;
                    endcase
                end
                6'b001101: begin  // ori
                    ctrl.aluSrc   = {`ALUSRC2_IMM_SHAMT, `ALUSRC1_RS};
                    ctrl.extOp    = `EXTOP_ZERO;
                    ctrl.aluOp    = `ALUOP_OR;
                    ctrl.regSrc   = `REGSRC_ALU;
                    ctrl.regDst   = `REGDST_RT;
                    ctrl.regWrite = `REGWRITE_NOCOND;
                    ctrl.tUseRs   = 2'd1;
                    ctrl.tNew     = ALU_NEW;
                end
                6'b001111: begin  // lui
                    ctrl.aluSrc   = {`ALUSRC2_IMM_SHAMT, `ALUSRC1_RS};
                    ctrl.extOp    = `EXTOP_UPPER;
                    ctrl.aluOp    = `ALUOP_OR;
                    ctrl.regSrc   = `REGSRC_ALU;
                    ctrl.regDst   = `REGDST_RT;
                    ctrl.regWrite = `REGWRITE_NOCOND;
                    ctrl.tUseRs   = 2'd1;
                    ctrl.tNew     = ALU_NEW;
                end
                6'b100011: begin  // lw
                    ctrl.aluSrc   = {`ALUSRC2_IMM_SHAMT, `ALUSRC1_RS};
                    ctrl.extOp    = `EXTOP_SIGN;
                    ctrl.aluOp    = `ALUOP_ADD;
                    ctrl.dmOp     = {`DMOP_WORD, `MEMREAD};
                    ctrl.regSrc   = `REGSRC_MEM;
                    ctrl.regDst   = `REGDST_RT;
                    ctrl.regWrite = `REGWRITE_NOCOND;
                    ctrl.tUseRs   = 2'd1;
                    ctrl.tNew     = LOAD_NEW;
                end
                6'b101011: begin  // sw, store data needed one stage later
                    ctrl.aluSrc   = {`ALUSRC2_IMM_SHAMT, `ALUSRC1_RS};
                    ctrl.extOp    = `EXTOP_SIGN;
                    ctrl.aluOp    = `ALUOP_ADD;
                    ctrl.dmOp     = {`DMOP_WORD, `MEMWRITE};
                    ctrl.tUseRs   = 2'd1;
                    ctrl.tUseRt   = 2'd2;
                end
                6'b000100: begin  // beq
                    ctrl.aluSrc   = {`ALUSRC2_RT, `ALUSRC1_RS};
                    ctrl.branch   = `BRANCH_COND;
                    ctrl.cmpOp    = `CMPOP_EQ;
                    ctrl.cmpSrc   = `CMPSRC_RT;
                end
                6'b000011: begin  // jal
                    ctrl.jump     = `JUMP_INDEX;
                    ctrl.regSrc   = `REGSRC_PC;
                    ctrl.regDst   = `REGDST_RA;
                    ctrl.regWrite = `REGWRITE_NOCOND;
                    ctrl.tNew     = LINK_NEW;
                end
                default: ;  // unknown stays idle
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/hazardPipeTop.sv
`include "mipsParams.svh"
`default_nettype none

module hazardPipeTop (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire mipsPkg::instrWord_t fetchInstr,
    output logic                     stall,
    output mipsPkg::fwdSel_t         fwdRs,
    output mipsPkg::fwdSel_t         fwdRt,
    output mipsPkg::instrWord_t      retireInstr
);
    import mipsPkg::*;

    regIndex_t decodeRs;
    regIndex_t decodeRt;
    timing_t   decodeUseRs;
    timing_t   decodeUseRt;

    wire instrWord_t [`NUM_SLOTS:0]   stageInstr;  // [0] is decode
    wire slotInfo_t  [`NUM_SLOTS-1:0] slotView;

    issueStage issueStage_inst (
        .clk,
        .reset,
        .fetchInstr,
        .stall,
        .decodeInstr(stageInstr[0]),
        .decodeRs,
        .decodeRt,
        .decodeUseRs,
        .decodeUseRt
    );

    for (genvar g = 0; g < `NUM_SLOTS; g++) begin : slotGen
        stageSlot #(
            .STAGE(`STAGE_EXECUTE + g)
        ) stageSlot_inst (
            .clk,
            .reset,
            .stall,
            .prevInstr(stageInstr[g]),
            .instr    (stageInstr[g+1]),
            .info     (slotView[g])
        );
    end

    hazardUnit hazardUnit_inst (
        .decodeRs,
        .decodeRt,
        .decodeUseRs,
        .decodeUseRt,
        .slotView,
        .stall,
        .fwdRs,
        .fwdRt
    );

    assign retireInstr = stageInstr[`NUM_SLOTS];

endmodule

`default_nettype wire

// File: logic/hazardUnit.sv
`include "mipsParams.svh"
`default_nettype none

module hazardUnit (
    input  wire mipsPkg::regIndex_t                  decodeRs,
    input  wire mipsPkg::regIndex_t                  decodeRt,
    input  wire mipsPkg::timing_t                    decodeUseRs,
    input  wire mipsPkg::timing_t                    decodeUseRt,
    input  wire mipsPkg::slotInfo_t [`NUM_SLOTS-1:0] slotView,
    output logic                                     stall,
    output mipsPkg::fwdSel_t                         fwdRs,
    output mipsPkg::fwdSel_t                         fwdRt
);
    import mipsPkg::*;

    logic stallRs;
    logic stallRt;

    // youngest matching slot wins, index 0 is execute
    function automatic fwdSel_t pickSource(
        input  regIndex_t                  idx,
        input  timing_t                    useTime,
        input  slotInfo_t [`NUM_SLOTS-1:0] view,
        output logic                       needStall
    );
        logic    hit;
        fwdSel_t sel;
        hit       = 1'b0;
        sel       = fwdNone;
        needStall = 1'b0;
        if (idx != '0 && useTime != `T_USE_IGNORE) begin
            for (int i = 0; i < `NUM_SLOTS; i++) begin
                if (!hit && view[i].dest == idx) begin
                    hit       = 1'b1;
                    needStall = view[i].tNew > useTime;
                    if (view[i].tNew == `T_NEW_IGNORE) begin
                        sel = fwdSel_t'(i + 1);  // value already computed
                    end
                end
            end
        end
        return sel;
    endfunction

    always_comb begin
        fwdRs = pickSource(decodeRs, decodeUseRs, slotView, stallRs);
        fwdRt = pickSource(decodeRt, decodeUseRt, slotView, stallRt);
    end

    assign stall = stallRs | stallRt;

    // decode reads nothing, so nothing can hold it
    always_comb begin
        noIdleStall: assert final (
            !(stall && decodeUseRs == `T_USE_IGNORE && decodeUseRt == `T_USE_IGNORE)
        ) else $error("stall raised with no operand in use");
    end

endmodule

`default_nettype wire

// File: logic/issueStage.sv
`include "mipsParams.svh"
`default_nettype none

module issueStage (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire mipsPkg::instrWord_t fetchInstr,
    input  wire logic                stall,
    output mipsPkg::instrWord_t      decodeInstr,
    output mipsPkg::regIndex_t       decodeRs,
    output mipsPkg::regIndex_t       decodeRt,
    output mipsPkg::timing_t         decodeUseRs,
    output mipsPkg::timing_t         decodeUseRt
);
    import mipsPkg::*;

    ctrlBundle_t decodeCtrl;

    always_ff @(posedge clk) begin
        if (reset) begin
            decodeInstr <= '0;  // nop
        end else if (!stall) begin
            decodeInstr <= fetchInstr;
        end
    end

    controlDecoder #(
        .PIPELINE(`STAGE_DECODE)
    ) controlDecoder_inst (
        .instr(decodeInstr),
        .ctrl (decodeCtrl)
    );

    assign decodeRs    = decodeInstr[`RS_MSB:`RS_LSB];
    assign decodeRt    = decodeInstr[`RT_MSB:`RT_LSB];
    assign decodeUseRs = decodeCtrl.tUseRs;
    assign decodeUseRt = decodeCtrl.tUseRt;

    // a stalled instruction must still be here next cycle
    holdOnStall: assert property (
        @(posedge clk) disable iff (reset) stall |=> $stable(decodeInstr)
    ) else $error("decode instruction changed under stall");

endmodule

`default_nettype wire

// File: logic/mipsParams.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

`define OPCODE_MSB 31
`define OPCODE_LSB 26
`define RS_MSB 25
`define RS_LSB 21
`define RT_MSB 20
`define RT_LSB 16
`define RD_MSB 15
`define RD_LSB 11
`define FUNCT_MSB 5
`define FUNCT_LSB 0

`define REG_RA 5'd31  // jal link register

`define STAGE_DECODE 0
`define STAGE_EXECUTE 1
`define STAGE_MEMORY 2
`define STAGE_WRITEBACK 3
`define STAGE_DEFAULT `STAGE_DECODE

`define NUM_SLOTS 3  // execute, memory, writeback

`define ALUSRC1_RS 1'b0
`define ALUSRC2_RT 2'b00
`define ALUSRC2_IMM_SHAMT 2'b01
`define ALUSRC_IGNORE 3'b000
`define REGSRC_ALU 2'd0
`define REGSRC_MEM 2'd1
`define REGSRC_PC 2'd2
`define REGSRC_IGNORE 2'd0
`define REGDST_RD 2'd0
`define REGDST_RT 2'd1
`define REGDST_RA 2'd2
`define REGDST_IGNORE 2'd0
`define REGWRITE_DISABLE 2'd0
`define REGWRITE_NOCOND 2'd1
`define DMOP_WORD 2'b01
`define MEMREAD 2'b01
`define MEMWRITE 2'b10
`define DMOP_IGNORE 4'b0000
`define BRANCH_DISABLE 2'd0
`define BRANCH_COND 2'd1
`define JUMP_DISABLE 2'd0
`define JUMP_INDEX 2'd1
`define JUMP_REG 2'd2
`define EXTOP_ZERO 2'd0
`define EXTOP_SIGN 2'd1
`define EXTOP_UPPER 2'd2
`define EXTOP_IGNORE 2'd0
`define ALUOP_ADD 4'd0
`define ALUOP_SUB 4'd1
`define ALUOP_OR 4'd2
`define ALUOP_IGNORE 4'd0
`define CMPOP_EQ 3'd1
`define CMPOP_IGNORE 3'd0
`define CMPSRC_RT 1'b1
`define CMPSRC_IGNORE 1'b0

`define T_USE_IGNORE 2'd3  // operand never read
`define T_NEW_IGNORE 2'd0  // nothing pending

`endif

// File: logic/mipsPkg.sv
`default_nettype none

package mipsPkg;

    typedef logic [31:0] instrWord_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  regIndex_t;

    // cycles until use or until result, same width for both
    typedef logic [1:0]  timing_t;

    typedef struct packed {
        logic [1:0] branch;
        logic [1:0] jump;
        logic       cmpSrc;
        logic [2:0] cmpOp;
        logic [1:0] extOp;
        logic [2:0] aluSrc;    // {src2, src1}
        logic [3:0] aluOp;
        logic [3:0] dmOp;      // {width, read/write}
        logic [1:0] regSrc;
        logic [1:0] regDst;
        logic [1:0] regWrite;
        timing_t    tUseRs;
        timing_t    tUseRt;
        timing_t    tNew;
    } ctrlBundle_t;

    // what the hazard unit needs from each older stage
    typedef struct packed {
        regIndex_t dest;       // 0 when nothing is written
        timing_t   tNew;
    } slotInfo_t;

    typedef enum logic [1:0] {
        fwdNone      = 2'd0,
        fwdExecute   = 2'd1,
        fwdMemory    = 2'd2,
        fwdWriteback = 2'd3
    } fwdSel_t;

endpackage

`default_nettype wire

// File: logic/stageSlot.sv
`include "mipsParams.svh"
`default_nettype none

module stageSlot #(
    parameter int STAGE = `STAGE_EXECUTE
) (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                stall,
    input  wire mipsPkg::instrWord_t prevInstr,
    output mipsPkg::instrWord_t      instr,
    output mipsPkg::slotInfo_t       info
);
    import mipsPkg::*;

    ctrlBundle_t slotCtrl;

    always_ff @(posedge clk) begin
        if (reset) begin
            instr <= '0;
        end else if (STAGE == `STAGE_EXECUTE && stall) begin
            instr <= '0;  // bubble behind the held decode
        end else begin
            instr <= prevInstr;
        end
    end

    // re-decode to learn the remaining distance
    controlDecoder #(
        .PIPELINE(STAGE)
    ) controlDecoder_inst (
        .instr(instr),
        .ctrl (slotCtrl)
    );

    always_comb begin
        case (slotCtrl.regDst)
            `REGDST_RD: info.dest = instr[`RD_MSB:`RD_LSB];
            `REGDST_RT: info.dest = instr[`RT_MSB:`RT_LSB];
            `REGDST_RA: info.dest = `REG_RA;
            default:    info.dest = '0;
        endcase
        if (slotCtrl.regWrite == `REGWRITE_DISABLE) begin
            info.dest = '0;  // stores and branches never match
        end
        info.tNew = slotCtrl.tNew;
    end

    destNeedsWrite: assert property (
        @(posedge clk) disable iff (reset)
        (info.dest != '0) |-> (slotCtrl.regWrite != `REGWRITE_DISABLE)
    ) else $error("slot %0d exposes a destination without a write", STAGE);

endmodule

`default_nettype wire
